// File: run_sim.sh
#!/bin/sh
# Build the padder testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_sha_block_padder -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: source/sha_block_buffer.sv
// 1024-bit block register of the padder
// Word insertion with optional byte swap, padding rewrite and the length block
`default_nettype none

module sha_block_buffer
  import sha_block_pkg::*;
(
  input  logic     clk,
  input  logic     rst_b,
  input  logic     accept_cmd,
  input  logic     cmd_swap,
  input  logic     accept_word,
  input  word_t    word,
  input  logic     clear_block,
  input  logic     pad_last,
  input  logic     pad_extra,
  input  msg_len_t msg_len,
  output block_t   data
);

  block_t    block_q;
  word_idx_t wr_idx_q;
  logic      swap_q;
  word_t     store_word;
  byte_idx_t tail_bytes;
  logic      len_fits;
  // Byte 0 is the most significant byte of the block, as the hash core expects
  logic [0:BYTES_PER_BLOCK-1][7:0] pad_bytes;
  logic [LEN_FIELD_BYTES*8-1:0]    len_bits;
  logic [0:LEN_FIELD_BYTES-1][7:0] len_bytes;

  // --------------------------------------------------------------------
  // Control state
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_idx_q <= '0;
      swap_q   <= 1'b0;
    end else begin
      if (accept_cmd) swap_q <= cmd_swap;
      if (accept_cmd || clear_block) wr_idx_q <= '0;
      else if (accept_word) wr_idx_q <= wr_idx_q + word_idx_t'(1);
    end
  end

  // Reverse the byte order of each word for little-endian sources
  assign store_word = swap_q ? {<<8{word}} : word;

  // --------------------------------------------------------------------
  // Padding rewrite
  // --------------------------------------------------------------------

  assign tail_bytes = msg_len[6:0];
  assign len_fits   = (tail_bytes < byte_idx_t'(PAD_LIMIT));
  // The length in bits sits right aligned in the 128-bit field
  assign len_bits   = (LEN_FIELD_BYTES*8)'(msg_len) << 3;
  assign len_bytes  = len_bits;

  always_comb begin
    pad_bytes = block_q;
    if (pad_extra) begin
      // Extra block carries only zeroes and the length
      pad_bytes = '0;
      for (int b = 0; b < LEN_FIELD_BYTES; b++) begin
        pad_bytes[PAD_LIMIT+b] = len_bytes[b];
      end
    end else begin
      // Keep the valid data bytes and clear the stale rest of the word
      for (int b = 0; b < BYTES_PER_BLOCK; b++) begin
        if (b >= tail_bytes) pad_bytes[b] = 8'h00;
      end
      // Single one bit right after the last data byte
      pad_bytes[tail_bytes] = 8'h80;
      if (len_fits) begin
        for (int b = 0; b < LEN_FIELD_BYTES; b++) begin
          pad_bytes[PAD_LIMIT+b] = len_bytes[b];
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Block storage
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept_cmd || clear_block) begin
      block_q <= '0;
    end else if (pad_last || pad_extra) begin
      block_q <= pad_bytes;
    end else if (accept_word) begin
      // First word of the message lands in the top 32 bits
      for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
        if (wr_idx_q == word_idx_t'(w)) block_q[BLOCK_W-1-w*WORD_W -: WORD_W] <= store_word;
      end
    end
  end

  assign data = block_q;

endmodule

`default_nettype wire

// File: source/sha_block_padder.sv
// Top level of the SHA-512 block assembler and padder
// Joins the control FSM, the word counter and the block buffer
`default_nettype none

module sha_block_padder
  import sha_block_pkg::*;
(
  input  logic       clk,
  input  logic       rst_b,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  pad_cmd_t   cmd,
  input  logic       word_valid,
  output logic       word_ready,
  input  word_t      word,
  output logic       blk_valid,
  input  logic       blk_ready,
  output block_out_t blk
);

  // Strobes from the FSM
  logic accept_cmd;
  logic accept_word;
  logic clear_block;
  logic pad_last;
  logic pad_extra;
  logic first;
  logic last;
  // Status from the counter
  logic     block_full;
  logic     words_done;
  logic     extra_needed;
  msg_len_t msg_len;
  block_t   block_data;

  sha_pad_fsm u_fsm (
    .clk          (clk),
    .rst_b        (rst_b),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .word_valid   (word_valid),
    .word_ready   (word_ready),
    .blk_valid    (blk_valid),
    .blk_ready    (blk_ready),
    .block_full   (block_full),
    .words_done   (words_done),
    .extra_needed (extra_needed),
    .accept_cmd   (accept_cmd),
    .accept_word  (accept_word),
    .clear_block  (clear_block),
    .pad_last     (pad_last),
    .pad_extra    (pad_extra),
    .first        (first),
    .last         (last)
  );

  sha_word_counter u_counter (
    .clk          (clk),
    .rst_b        (rst_b),
    .accept_cmd   (accept_cmd),
    .cmd_len      (cmd.msg_len),
    .accept_word  (accept_word),
    .clear_block  (clear_block),
    .msg_len      (msg_len),
    .block_full   (block_full),
    .words_done   (words_done),
    .extra_needed (extra_needed)
  );

  sha_block_buffer u_buffer (
    .clk         (clk),
    .rst_b       (rst_b),
    .accept_cmd  (accept_cmd),
    .cmd_swap    (cmd.swap_bytes),
    .accept_word (accept_word),
    .word        (word),
    .clear_block (clear_block),
    .pad_last    (pad_last),
    .pad_extra   (pad_extra),
    .msg_len     (msg_len),
    .data        (block_data)
  );

  // Flags travel with the block so the core can pick init or next
  assign blk.data  = block_data;
  assign blk.first = first;
  assign blk.last  = last;

endmodule

`default_nettype wire

// File: source/sha_block_pkg.sv
// Shared definitions for the SHA-512 block assembler and padder
// Widths and field types, the padder state encoding and the channel structs
`default_nettype none

package sha_block_pkg;

  // --------------------------------------------------------------------
  // Sizes fixed by the SHA-512 message schedule
  // --------------------------------------------------------------------

  // Bits in one incoming message word
  localparam int WORD_W = 32;
  // Bits in one hash block
  localparam int BLOCK_W = 1024;
  localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;
  localparam int BYTES_PER_BLOCK = BLOCK_W / 8;
  // The bit length of the message sits in the last 128 bits of the final block
  localparam int LEN_FIELD_BYTES = 16;
  // Data bytes in the last block beyond this leave no room for the length field
  localparam int PAD_LIMIT = BYTES_PER_BLOCK - LEN_FIELD_BYTES;

  // --------------------------------------------------------------------
  // Field types
  // --------------------------------------------------------------------

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [BLOCK_W-1:0] block_t;
  // Message length in bytes, as given by the command
  typedef logic [31:0]        msg_len_t;
  // One extra bit so that a count of 32 reads as a full block
  typedef logic [5:0]         word_idx_t;
  typedef logic [6:0]         byte_idx_t;

  // Padder sequencing where PAD_LAST and PAD_EXTRA each rewrite the block for one cycle
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    SEND,
    PAD_LAST,
    PAD_EXTRA,
    PAD_SEND
  } pad_state_e;

  // Command that opens a message
  typedef struct packed {
    msg_len_t msg_len;
    logic     swap_bytes;
  } pad_cmd_t;

  // Block handed to the hash core where first selects init against next
  typedef struct packed {
    block_t data;
    logic   first;
    logic   last;
  } block_out_t;

endpackage

`default_nettype wire

// File: source/sha_pad_fsm.sv
// Control FSM of the block padder
// Sequences word loading, block hand-off, padding and the extra length block
`default_nettype none

module sha_pad_fsm
  import sha_block_pkg::*;
(
  input  logic clk,
  input  logic rst_b,
  input  logic cmd_valid,
  output logic cmd_ready,
  input  logic word_valid,
  output logic word_ready,
  output logic blk_valid,
  input  logic blk_ready,
  input  logic block_full,
  input  logic words_done,
  input  logic extra_needed,
  output logic accept_cmd,
  output logic accept_word,
  output logic clear_block,
  output logic pad_last,
  output logic pad_extra,
  output logic first,
  output logic last
);

  pad_state_e state_q;
  pad_state_e state_d;
  logic       first_q;
  // Marks that the block now in PAD_SEND is the zero and length block
  logic       extra_sent_q;
  logic       blk_xfer;

  // --------------------------------------------------------------------
  // Handshakes and strobes
  // --------------------------------------------------------------------

  assign cmd_ready  = (state_q == IDLE);
  assign accept_cmd = cmd_valid & cmd_ready;

  // Stop taking words once the block is full or the length is reached
  assign word_ready  = (state_q == LOAD) & ~block_full & ~words_done;
  assign accept_word = word_valid & word_ready;

  assign blk_valid = (state_q == SEND) | (state_q == PAD_SEND);
  assign blk_xfer  = blk_valid & blk_ready;

  // A plain data block leaves, so the next one starts empty
  assign clear_block = (state_q == SEND) & blk_ready;
  assign pad_last    = (state_q == PAD_LAST);
  assign pad_extra   = (state_q == PAD_EXTRA);

  assign first = first_q;
  // Only a padded block can close the message
  assign last  = (state_q == PAD_SEND) & (extra_sent_q | ~extra_needed);

  // --------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept_cmd) state_d = LOAD;
      end
      LOAD: begin
        // A full block goes out first, even when the message ends with it
        if (block_full) state_d = SEND;
        else if (words_done) state_d = PAD_LAST;
      end
      SEND: begin
        if (blk_ready) state_d = LOAD;
      end
      PAD_LAST,
      PAD_EXTRA: begin
        state_d = PAD_SEND;
      end
      PAD_SEND: begin
        if (blk_ready) state_d = last ? IDLE : PAD_EXTRA;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q      <= IDLE;
      first_q      <= 1'b0;
      extra_sent_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // The hash core starts a new digest on the first block of each message
      if (accept_cmd) first_q <= 1'b1;
      else if (blk_xfer) first_q <= 1'b0;
      if (accept_cmd) extra_sent_q <= 1'b0;
      else if (pad_extra) extra_sent_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/sha_word_counter.sv
// Word and byte counter of the block padder
// Holds the commanded length and tells when a block is full or the message ends
`default_nettype none

module sha_word_counter
  import sha_block_pkg::*;
(
  input  logic     clk,
  input  logic     rst_b,
  input  logic     accept_cmd,
  input  msg_len_t cmd_len,
  input  logic     accept_word,
  input  logic     clear_block,
  output msg_len_t msg_len,
  output logic     block_full,
  output logic     words_done,
  output logic     extra_needed
);

  msg_len_t  len_q;
  word_idx_t word_cnt_q;
  // Counts whole words, so it may run past a length that is not a multiple of 4
  msg_len_t  bytes_taken_q;
  // Data bytes that land in the final block
  byte_idx_t tail_bytes;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      len_q         <= '0;
      word_cnt_q    <= '0;
      bytes_taken_q <= '0;
    end else begin
      if (accept_cmd) len_q <= cmd_len;

      if (accept_cmd || clear_block) word_cnt_q <= '0;
      else if (accept_word) word_cnt_q <= word_cnt_q + word_idx_t'(1);

      if (accept_cmd) bytes_taken_q <= '0;
      else if (accept_word) bytes_taken_q <= bytes_taken_q + msg_len_t'(WORD_W / 8);
    end
  end

  assign msg_len    = len_q;
  assign block_full = (word_cnt_q == word_idx_t'(WORDS_PER_BLOCK));
  assign words_done = (bytes_taken_q >= len_q);

  // A length on a block boundary pads into a fresh block, so the tail is zero
  assign tail_bytes   = len_q[6:0];
  assign extra_needed = (tail_bytes >= byte_idx_t'(PAD_LIMIT));

endmodule

`default_nettype wire

// File: tb.f
source/sha_block_pkg.sv
source/sha_pad_fsm.sv
source/sha_word_counter.sv
source/sha_block_buffer.sv
source/sha_block_padder.sv
tb/tb_clock_gen.sv
tb/tb_sha_block_padder.sv

// File: tb/tb_clock_gen.sv
// Free-running clock for the padder testbench
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  // Half the period low, half high
  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tb/tb_sha_block_padder.sv
// Testbench of the SHA-512 block assembler and padder
// Directed and random messages, a SHA-512 padding model, the checker and a watchdog
`default_nettype none

module tb_sha_block_padder
  import sha_block_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int SEED = 51558;
  // Cycle budget per test where the stalled random message dominates
  localparam int TEST_CYCLES = 40 + 80 + 120 + 40 + 30 + 1200;
  localparam int WATCHDOG_TIME = (2 * TEST_CYCLES + 8) * CLK_PERIOD;

  logic       clk;
  logic       rst_b;
  logic       cmd_valid;
  logic       cmd_ready;
  pad_cmd_t   cmd;
  logic       word_valid;
  logic       word_ready;
  word_t      word;
  logic       blk_valid;
  logic       blk_ready;
  block_out_t blk;
  int         errors;
  int         test_errors;
  int         tests_run;
  int         tests_failed;
  word_t      words_q[$];
  block_out_t got_q[$];

  tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

  sha_block_padder UUT (
    .clk        (clk),
    .rst_b      (rst_b),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .word       (word),
    .blk_valid  (blk_valid),
    .blk_ready  (blk_ready),
    .blk        (blk)
  );

  task automatic check_val(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
      $display("Error %s got %0h expected %0h", name, got, exp);
      test_errors++;
    end
  endtask

  // --------------------------------------------------------------------
  // One message with its command, words, blocks and the model comparison
  // --------------------------------------------------------------------

  task automatic run_message(input string name, input int len, input logic swap,
                             input logic stall);
    int         nwords;
    int         wi;
    int         nblk;
    logic       w_xfer;
    logic       done;
    logic       busy;
    logic       held_ok;
    block_out_t held;
    word_t      src;
    block_t     exp_blk;
    logic [127:0] len_field;
    logic [7:0] pad[$];
    test_errors = 0;
    words_q.delete();
    got_q.delete();
    nwords = (len + 3) / 4;
    // Random fill also covers the stale bytes past the end of the last word
    for (int i = 0; i < nwords; i++) words_q.push_back($urandom);
    @(posedge clk);
    cmd_valid      <= 1'b1;
    cmd.msg_len    <= msg_len_t'(len);
    cmd.swap_bytes <= swap;
    wi = 0;
    done = 1'b0;
    busy = 1'b0;
    held_ok = 1'b0;
    while (!done) begin
      // Outputs are settled at the falling edge and transfers happen at the next rise
      @(negedge clk);
      w_xfer = word_valid && word_ready;
      if (w_xfer) wi++;
      // No second command may be taken while a message is in flight
      if (busy) check_val("cmd_ready", block_t'(cmd_ready), '0);
      if (cmd_valid && cmd_ready) busy = 1'b1;
      // The word channel rests while a block waits for the core
      check_val("word_ready", block_t'(word_ready && blk_valid), '0);
      if (held_ok && (!blk_valid || blk !== held)) begin
        $display("Block or blk_valid changed while blk_ready was low");
        test_errors++;
      end
      held_ok = 1'b0;
      if (blk_valid && blk_ready) begin
        got_q.push_back(blk);
        done = blk.last;
      end else if (blk_valid) begin
        held = blk;
        held_ok = 1'b1;
      end
      @(posedge clk);
      cmd_valid <= !busy;
      blk_ready <= stall ? 1'($urandom_range(1)) : 1'b1;
      // A raised word_valid holds with its word until it is taken
      if (wi < nwords && ((word_valid && !w_xfer) || !stall || $urandom_range(2) != 0)) begin
        word_valid <= 1'b1;
        word       <= words_q[wi];
      end else begin
        word_valid <= 1'b0;
      end
    end
    // Every word of the message is taken and none beyond it
    check_val("words taken", block_t'(wi), block_t'(nwords));
    // SHA-512 padding puts 0x80 and zeroes up to 112 mod 128 and then the 128-bit bit count
    for (int i = 0; i < len; i++) begin
      src = words_q[i / 4];
      // A swapped source sends the first byte in the low lane
      pad.push_back(swap ? src[8*(i%4) +: 8] : src[31-8*(i%4) -: 8]);
    end
    pad.push_back(8'h80);
    while (pad.size() % BYTES_PER_BLOCK != PAD_LIMIT) pad.push_back(8'h00);
    len_field = 128'(len) * 128'd8;
    for (int i = LEN_FIELD_BYTES - 1; i >= 0; i--) pad.push_back(len_field[8*i +: 8]);
    nblk = pad.size() / BYTES_PER_BLOCK;
    check_val("block count", block_t'(got_q.size()), block_t'(nblk));
    for (int k = 0; k < nblk && k < got_q.size(); k++) begin
      for (int j = 0; j < BYTES_PER_BLOCK; j++) exp_blk[BLOCK_W-1-8*j -: 8] = pad[128*k+j];
      check_val($sformatf("blk.data[%0d]", k), got_q[k].data, exp_blk);
      check_val($sformatf("blk.first[%0d]", k), block_t'(got_q[k].first), block_t'(k == 0));
      check_val($sformatf("blk.last[%0d]", k), block_t'(got_q[k].last), block_t'(k == nblk - 1));
    end
    tests_run++;
    if (test_errors != 0) tests_failed++;
    errors += test_errors;
    $display("Test %s: length %0d, %0d blocks, %0d errors, %s", name, len, got_q.size(),
             test_errors, (test_errors == 0) ? "passed" : "FAILED");
  endtask

  // --------------------------------------------------------------------
  // Test sequence and watchdog
  // --------------------------------------------------------------------

  initial begin
    void'($urandom(SEED));
    rst_b = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    word_valid = 1'b0;
    word = '0;
    blk_ready = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    rst_b <= 1'b1;
    run_message("single block", 3, 1'b0, 1'b0);
    run_message("extra length block", 120, 1'b0, 1'b0);
    run_message("block boundary", 256, 1'b0, 1'b0);
    run_message("byte swap", 9, 1'b1, 1'b0);
    run_message("empty message", 0, 1'b0, 1'b0);
    run_message("random with stalls", int'($urandom_range(400)), 1'($urandom_range(1)), 1'b1);
    $display("Tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired before the last block of a message arrived");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
